// ==== Bender.yml ====
package:
  name: portalSupervisor

sources:
  - include_dirs:
      - common
    files:
      - common/portalPkg.sv
      - rtl/portalCfgDecode.sv
      - throttle/msgThrottle.sv
      - rtl/portalGuard.sv
      - rtl/portalSupervisor.sv
  - target: test
    include_dirs:
      - common
    files:
      - dv/clockGen.sv
      - dv/portalSupervisor_properties.sv
      - dv/portalSupervisor_tb.sv

// ==== common/portalCtl_consts.svh ====
`ifndef PORTALCTL_CONSTS_SVH
`define PORTALCTL_CONSTS_SVH

// configuration port widths
`define PORTAL_CFG_ADDR_W 6
`define PORTAL_CFG_DATA_W 32

// task parameter widths
`define PORTAL_PSO_W 24
`define PORTAL_TASK_W 16
`define PORTAL_CPL_W 2
`define PORTAL_CPL_LSB 18

// throttle and status widths
`define PORTAL_CNT_W 8
`define PORTAL_BUDGET_LSB 16
`define PORTAL_TIMER_W 16
`define PORTAL_CTRL_W 16
`define PORTAL_STATE_W 32

// clock cycles per tick
`define PORTAL_TICK_SCALE 20

// register map
`define PORTAL_ADDR_CTRL 6'h38
`define PORTAL_ADDR_RATE 6'h39
`define PORTAL_ADDR_TASK 6'h3B
`define PORTAL_ADDR_PSO 6'h3C

// flag bits in register 38h
`define PORTAL_BIT_SOE 21
`define PORTAL_BIT_ER 20

`endif

// ==== common/portalPkg.sv ====
package portalPkg;

`include "portalCtl_consts.svh"

	// configuration registers known to the portal
	typedef enum logic [`PORTAL_CFG_ADDR_W-1:0]
	{
		cfgCtrl = `PORTAL_ADDR_CTRL,
		cfgRate = `PORTAL_ADDR_RATE,
		cfgTask = `PORTAL_ADDR_TASK,
		cfgPso  = `PORTAL_ADDR_PSO
	} cfgRegKind;

	// portal datapath lock
	typedef enum logic
	{
		open   = 1'b0,
		locked = 1'b1
	} lockState;

endpackage

// ==== dv/clockGen.sv ====
`timescale 1ns/1ps

module clockGen #(
	parameter int periodNs    = 4,
	parameter int resetCycles = 2
) (
	output logic EXTCLK,
	output logic RST
);

	initial
	begin
		EXTCLK = 1'b0;
		forever
			#(periodNs / 2.0) EXTCLK = ~EXTCLK;
	end

	// release on a falling edge, away from the sampling edge
	initial
	begin
		RST = 1'b0;
		repeat (resetCycles) @(posedge EXTCLK);
		@(negedge EXTCLK);
		RST = 1'b1;
	end

endmodule

// ==== dv/portalSupervisor_properties.sv ====
`timescale 1ns/1ps

module portalSupervisor_properties (
	input logic                 EXTCLK,
	input logic                 RST,
	input logic                 smsgGrant,
	input logic                 portalSmsg,
	input logic                 portalRun,
	input portalPkg::lockState  lockReg,
	input logic                 errReport,
	input logic                 mcErrStb
);

	import portalPkg::*;

	int assertFails = 0;

	// grant only for a waiting requester
	grantNeedsRequest: assert property (@(posedge EXTCLK) disable iff (!RST)
		smsgGrant |-> portalSmsg)
	else
	begin
		assertFails++;
		$error("smsgGrant high without portalSmsg");
	end

	// run always opens the lock
	runOpensLock: assert property (@(posedge EXTCLK) disable iff (!RST)
		portalRun |=> (lockReg == open))
	else
	begin
		assertFails++;
		$error("lock still closed one cycle after portalRun");
	end

	errNeedsStrobe: assert property (@(posedge EXTCLK) disable iff (!RST)
		errReport |-> mcErrStb)
	else
	begin
		assertFails++;
		$error("errReport high without mcErrStb");
	end

endmodule

// throttle side, the guard signals tied off
bind msgThrottle portalSupervisor_properties u_throttleProps (
	.EXTCLK(EXTCLK), .RST(RST), .smsgGrant(smsgGrant), .portalSmsg(portalSmsg),
	.portalRun(1'b0), .lockReg(portalPkg::open), .errReport(1'b0), .mcErrStb(1'b0)
);

bind portalGuard portalSupervisor_properties u_guardProps (
	.EXTCLK(EXTCLK), .RST(RST), .smsgGrant(1'b0), .portalSmsg(1'b0),
	.portalRun(portalRun), .lockReg(lockReg), .errReport(errReport), .mcErrStb(mcErrStb)
);

// ==== dv/portalSupervisor_tb.sv ====
`timescale 1ns/1ps
`include "portalCtl_consts.svh"

module portalSupervisor_tb;

	import portalPkg::*;

	localparam int tickScale  = 8;
	localparam int numWrites  = 24;
	localparam int holdCycles = 40;
	localparam int winTicks   = 40;
	// all tests together, in clock cycles
	localparam int testCycles = 200 + numWrites * 4 + 2 * holdCycles + (winTicks + 4) * tickScale;
	localparam int watchdogNs = (testCycles + 500) * 4;

	logic                              EXTCLK;
	logic                              RST;
	logic                              cfgStb;
	logic                              cfgRst;
	logic [`PORTAL_CFG_ADDR_W-1:0]     cfgAddr;
	logic [`PORTAL_CFG_DATA_W-1:0]     cfgData;
	logic                              portalReady;
	logic                              portalActivation;
	logic [`PORTAL_CPL_W-1:0]          csrCpl;
	logic [`PORTAL_TASK_W-1:0]         csrTaskId;
	logic [`PORTAL_PSO_W-1:0]          cpsr;
	logic                              portalSmsg;
	logic                              mcErrStb;
	logic                              portalDis;
	logic                              portalRun;
	logic                              smsgGrant;
	logic                              errReport;
	logic                              portalRst;
	logic                              portalLock;
	logic [`PORTAL_CPL_W-1:0]          portalCpl;
	logic [`PORTAL_TASK_W-1:0]         portalTaskId;
	logic [`PORTAL_PSO_W-1:0]          portalPso;
	logic [`PORTAL_STATE_W-1:0]        portalState;

	// shadow of the register contents
	logic [15:0]                       shCtrl;
	logic                              shEr;
	logic                              shSoe;
	logic [`PORTAL_CPL_W-1:0]          shCpl;
	logic [`PORTAL_TASK_W-1:0]         shTask;
	logic [`PORTAL_PSO_W-1:0]          shPso;

	// one-shot requests to the compare process
	logic                              chkState;
	logic                              chkParams;
	logic                              chkErr;
	logic                              chkRst;
	logic                              chkLock;
	logic                              chkGrants;
	logic                              countGrants;
	logic [`PORTAL_STATE_W-1:0]        expState;
	logic [41:0]                       expParams;
	logic                              expErr;
	logic                              expRst;
	logic                              expLock;
	int                                expGrants;
	int                                grantCount;
	int                                checkCount;
	int                                errorCount;
	int                                assertFails;

	clockGen #(.periodNs(4), .resetCycles(2)) u_clockGen (.EXTCLK(EXTCLK), .RST(RST));

	portalSupervisor #(.tickScale(tickScale)) u_portalSupervisor (
		.EXTCLK(EXTCLK), .RST(RST), .cfgStb(cfgStb), .cfgRst(cfgRst),
		.cfgAddr(cfgAddr), .cfgData(cfgData), .portalReady(portalReady),
		.portalActivation(portalActivation), .csrCpl(csrCpl), .csrTaskId(csrTaskId),
		.cpsr(cpsr), .portalSmsg(portalSmsg), .mcErrStb(mcErrStb), .portalDis(portalDis),
		.portalRun(portalRun), .smsgGrant(smsgGrant), .errReport(errReport),
		.portalRst(portalRst), .portalLock(portalLock), .portalCpl(portalCpl),
		.portalTaskId(portalTaskId), .portalPso(portalPso), .portalState(portalState)
	);

	// ==============================
	// reference model
	// ==============================
	function automatic logic [`PORTAL_STATE_W-1:0] refState(
		input logic [`PORTAL_CFG_ADDR_W-1:0] addr);
		logic [`PORTAL_STATE_W-1:0] word;
		word = '0;
		case (addr)
			`PORTAL_ADDR_PSO:
				word[23:0] = shPso;
			`PORTAL_ADDR_TASK:
			begin
				word[19:18] = shCpl;
				word[15:0]  = shTask;
			end
			default:
				word[15:0] = shCtrl;
		endcase
		return word;
	endfunction

	function automatic logic [41:0] refParams();
		return {shCpl, shTask, shPso};
	endfunction

	task automatic applyWrite(input logic [`PORTAL_CFG_ADDR_W-1:0] addr, input logic [31:0] data);
		case (addr)
			`PORTAL_ADDR_CTRL:
			begin
				shCtrl = data[15:0];
				shSoe  = data[`PORTAL_BIT_SOE];
				shEr   = data[`PORTAL_BIT_ER];
			end
			`PORTAL_ADDR_TASK:
			begin
				shCpl  = data[19:18];
				shTask = data[15:0];
			end
			`PORTAL_ADDR_PSO:
				shPso = data[23:0];
			default:
				shPso = shPso;
		endcase
	endtask

	// one strobe cycle, returns on the next falling edge with the strobe low
	task automatic writeCfg(input logic [`PORTAL_CFG_ADDR_W-1:0] addr, input logic [31:0] data);
		@(negedge EXTCLK);
		cfgStb  = 1'b1;
		cfgAddr = addr;
		cfgData = data;
		applyWrite(addr, data);
		@(negedge EXTCLK);
		cfgStb = 1'b0;
	endtask

	task automatic holdSmsg(input int budget);
		grantCount  = 0;
		countGrants = 1'b1;
		portalSmsg  = 1'b1;
		repeat (holdCycles) @(negedge EXTCLK);
		portalSmsg  = 1'b0;
		countGrants = 1'b0;
		chkGrants   = 1'b1;
		expGrants   = budget;
		@(negedge EXTCLK);
	endtask

	task automatic compareValue(input string what, input logic [63:0] got, input logic [63:0] exp);
		checkCount++;
		if (got !== exp)
		begin
			errorCount++;
			$display("Error at %0t: %s is %0h, expected %0h", $time, what, got, exp);
		end
	endtask

	// ==============================
	// compare process
	// ==============================
	// samples before the edge, inputs settled since the falling edge
	always @(posedge EXTCLK)
	begin
		if (countGrants && smsgGrant)
			grantCount++;
		if (chkState)
			compareValue("portalState", portalState, expState);
		if (chkParams)
			compareValue("task parameters", {portalCpl, portalTaskId, portalPso}, expParams);
		if (chkErr)
			compareValue("errReport", errReport, expErr);
		if (chkRst)
			compareValue("portalRst", portalRst, expRst);
		if (chkLock)
			compareValue("portalLock", portalLock, expLock);
		if (chkGrants)
			compareValue("grant count", grantCount, expGrants);
		chkState  = 1'b0;
		chkParams = 1'b0;
		chkErr    = 1'b0;
		chkRst    = 1'b0;
		chkLock   = 1'b0;
		chkGrants = 1'b0;
	end

	// ==============================
	// stimulus
	// ==============================
	initial
	begin
		logic [`PORTAL_CFG_ADDR_W-1:0] wrAddr;
		logic [`PORTAL_CFG_ADDR_W-1:0] rdAddr;
		logic [31:0]                   wrData;
		int                            budgetN;
		void'($urandom(32'h42fe));
		cfgStb = 1'b0;
		cfgRst = 1'b0;
		cfgAddr = `PORTAL_ADDR_CTRL;
		cfgData = '0;
		portalReady = 1'b0;
		portalActivation = 1'b0;
		csrCpl = '0;
		csrTaskId = '0;
		cpsr = '0;
		portalSmsg = 1'b0;
		mcErrStb = 1'b0;
		portalDis = 1'b0;
		portalRun = 1'b0;
		{chkState, chkParams, chkErr, chkRst, chkLock, chkGrants, countGrants} = '0;
		{expState, expParams, expErr, expRst, expLock} = '0;
		expGrants = 0;
		grantCount = 0;
		checkCount = 0;
		errorCount = 0;
		shEr = 1'b1;
		shSoe = 1'b0;
		@(posedge RST);
		@(negedge EXTCLK);

		// error report straight out of reset, then with reporting off
		mcErrStb = 1'b1;
		{chkErr, chkRst, chkLock} = 3'b111;
		{expErr, expRst, expLock} = {shEr, 1'b1, 1'b0};
		@(negedge EXTCLK);
		mcErrStb = 1'b0;
		writeCfg(`PORTAL_ADDR_CTRL, 32'h0000_1234);
		mcErrStb = 1'b1;
		chkErr = 1'b1;
		expErr = shEr;
		@(negedge EXTCLK);
		mcErrStb = 1'b0;
		chkLock = 1'b1;
		expLock = 1'b0;

		// stop on error
		writeCfg(`PORTAL_ADDR_CTRL, 32'h0030_0000 | ($urandom & 32'hffff));
		mcErrStb = 1'b1;
		{chkErr, chkRst, chkLock} = 3'b111;
		{expErr, expRst, expLock} = {shEr, 1'b1, 1'b0};
		@(negedge EXTCLK);
		mcErrStb = 1'b0;
		{chkRst, chkLock} = 2'b11;
		{expRst, expLock} = {~shSoe, shSoe};
		@(negedge EXTCLK);
		{chkRst, chkLock} = 2'b11;
		{expRst, expLock} = 2'b11;
		repeat (3)
		begin
			@(negedge EXTCLK);
			chkLock = 1'b1;
			expLock = 1'b1;
		end
		portalRun = 1'b1;
		@(negedge EXTCLK);
		portalRun = 1'b0;
		chkLock = 1'b1;
		expLock = 1'b0;
		portalDis = 1'b1;
		@(negedge EXTCLK);
		portalDis = 1'b0;
		chkLock = 1'b1;
		expLock = 1'b1;
		portalRun = 1'b1;
		@(negedge EXTCLK);
		portalRun = 1'b0;
		chkLock = 1'b1;
		expLock = 1'b0;

		// random register writes and readback
		writeCfg(`PORTAL_ADDR_CTRL, 32'h0010_0000 | ($urandom & 32'hffff));
		writeCfg(`PORTAL_ADDR_TASK, $urandom);
		writeCfg(`PORTAL_ADDR_PSO, $urandom);
		for (int i = 0; i < numWrites; i++)
		begin
			case ($urandom % 3)
				0: wrAddr = `PORTAL_ADDR_CTRL;
				1: wrAddr = `PORTAL_ADDR_TASK;
				default: wrAddr = `PORTAL_ADDR_PSO;
			endcase
			wrData = $urandom;
			if (wrAddr == `PORTAL_ADDR_CTRL)
				wrData = (wrData & ~32'h0030_0000) | 32'h0010_0000;
			writeCfg(wrAddr, wrData);
			rdAddr = ($urandom % 2) ? wrAddr : (`PORTAL_ADDR_CTRL + 6'($urandom % 5));
			cfgAddr = rdAddr;
			chkParams = 1'b1;
			expParams = refParams();
			@(negedge EXTCLK);
			chkState = 1'b1;
			expState = refState(rdAddr);
			@(negedge EXTCLK);
		end

		// activation, then activation without ready, then against a write
		{csrCpl, csrTaskId, cpsr} = 42'({$urandom, $urandom});
		{portalReady, portalActivation} = 2'b11;
		{shCpl, shTask, shPso} = {csrCpl, csrTaskId, cpsr};
		@(negedge EXTCLK);
		chkParams = 1'b1;
		expParams = refParams();
		{csrCpl, csrTaskId, cpsr} = 42'({$urandom, $urandom});
		portalReady = 1'b0;
		@(negedge EXTCLK);
		portalActivation = 1'b0;
		chkParams = 1'b1;
		expParams = refParams();
		{csrCpl, csrTaskId, cpsr} = 42'({$urandom, $urandom});
		{portalReady, portalActivation} = 2'b11;
		cfgStb = 1'b1;
		cfgAddr = `PORTAL_ADDR_TASK;
		cfgData = $urandom;
		shPso = cpsr;
		applyWrite(cfgAddr, cfgData);
		@(negedge EXTCLK);
		{cfgStb, portalReady, portalActivation} = 3'b000;
		{chkParams, chkState} = 2'b11;
		expParams = refParams();
		expState = refState(cfgAddr);
		@(negedge EXTCLK);

		// message budget within one window, then after it expires
		budgetN = 1 + ($urandom % 8);
		writeCfg(`PORTAL_ADDR_RATE, {8'h00, budgetN[7:0], winTicks[15:0]});
		repeat (4) @(negedge EXTCLK);
		holdSmsg(budgetN);
		repeat ((winTicks + 4) * tickScale) @(negedge EXTCLK);
		holdSmsg(budgetN);

		repeat (2) @(negedge EXTCLK);
		assertFails = u_portalSupervisor.u_msgThrottle.u_throttleProps.assertFails
			+ u_portalSupervisor.u_portalGuard.u_guardProps.assertFails;
		$display("checks %0d, errors %0d, assertion failures %0d",
			checkCount, errorCount, assertFails);
		if (errorCount == 0 && assertFails == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

	// watchdog
	initial
	begin
		#(watchdogNs);
		$display("timeout: the tests did not complete within %0d ns", watchdogNs);
		$display("TEST FAILED");
		$finish;
	end

endmodule

// ==== portalSupervisor.f ====
+incdir+common
common/portalPkg.sv
rtl/portalCfgDecode.sv
throttle/msgThrottle.sv
rtl/portalGuard.sv
rtl/portalSupervisor.sv
dv/clockGen.sv
dv/portalSupervisor_properties.sv
dv/portalSupervisor_tb.sv

// ==== rtl/portalCfgDecode.sv ====
`timescale 1ns/1ps
`include "portalCtl_consts.svh"

module portalCfgDecode (
	input  logic                             EXTCLK,
	input  logic                             RST,
	input  logic                             cfgStb,
	input  logic [`PORTAL_CFG_ADDR_W-1:0]    cfgAddr,
	input  logic [`PORTAL_CFG_DATA_W-1:0]    cfgData,
	input  logic                             portalReady,
	input  logic                             portalActivation,
	input  logic [`PORTAL_CPL_W-1:0]         csrCpl,
	input  logic [`PORTAL_TASK_W-1:0]        csrTaskId,
	input  logic [`PORTAL_PSO_W-1:0]         cpsr,
	output logic                             soeFlag,
	output logic                             erFlag,
	output logic [`PORTAL_CTRL_W-1:0]        ctrlWord,
	output logic [`PORTAL_CPL_W-1:0]         portalCpl,
	output logic [`PORTAL_TASK_W-1:0]        portalTaskId,
	output logic [`PORTAL_PSO_W-1:0]         portalPso,
	output logic [`PORTAL_CNT_W-1:0]         budgetBase,
	output logic [`PORTAL_TIMER_W-1:0]       timerBase,
	output logic                             rateWrite,
	output portalPkg::cfgRegKind             readSel
);

	import portalPkg::*;

	cfgRegKind addrKind;
	logic      wrCtrl;
	logic      wrRate;
	logic      wrTask;
	logic      wrPso;
	logic      actLoad;

	// ==============================
	// address decode
	// ==============================
	assign addrKind = cfgRegKind'(cfgAddr);
	assign actLoad  = portalReady && portalActivation;

	always_comb
	begin
		wrCtrl = 1'b0;
		wrRate = 1'b0;
		wrTask = 1'b0;
		wrPso  = 1'b0;
		if (cfgStb)
		begin
			case (addrKind)
				cfgCtrl: wrCtrl = 1'b1;
				cfgRate: wrRate = 1'b1;
				cfgTask: wrTask = 1'b1;
				cfgPso:  wrPso  = 1'b1;
				default: wrCtrl = 1'b0;
			endcase
		end
	end

	// rate fields go straight to the throttle, which keeps its own copy
	assign budgetBase = cfgData[`PORTAL_BUDGET_LSB +: `PORTAL_CNT_W];
	assign timerBase  = cfgData[`PORTAL_TIMER_W-1:0];
	assign rateWrite  = wrRate;

	// ==============================
	// flags and readback select
	// ==============================
	always_ff @(posedge EXTCLK)
	begin
		if (!RST)
		begin
			soeFlag <= 1'b0;
			erFlag  <= 1'b1;
			readSel <= cfgCtrl;
		end
		else
		begin
			if (wrCtrl)
			begin
				soeFlag <= cfgData[`PORTAL_BIT_SOE];
				erFlag  <= cfgData[`PORTAL_BIT_ER];
			end
			readSel <= addrKind;
		end
	end

	// control word and task parameters, a config write beats activation
	always_ff @(posedge EXTCLK)
	begin
		if (wrCtrl)
			ctrlWord <= cfgData[`PORTAL_CTRL_W-1:0];
		if (wrTask)
		begin
			portalCpl    <= cfgData[`PORTAL_CPL_LSB +: `PORTAL_CPL_W];
			portalTaskId <= cfgData[`PORTAL_TASK_W-1:0];
		end
		else if (actLoad)
		begin
			portalCpl    <= csrCpl;
			portalTaskId <= csrTaskId;
		end
		if (wrPso)
			portalPso <= cfgData[`PORTAL_PSO_W-1:0];
		else if (actLoad)
			portalPso <= cpsr;
	end

endmodule

// ==== rtl/portalGuard.sv ====
`timescale 1ns/1ps
`include "portalCtl_consts.svh"

module portalGuard (
	input  logic                         EXTCLK,
	input  logic                         RST,
	input  logic                         mcErrStb,
	input  logic                         portalDis,
	input  logic                         portalRun,
	input  logic                         soeFlag,
	input  logic                         erFlag,
	input  logic [`PORTAL_CTRL_W-1:0]    ctrlWord,
	input  logic [`PORTAL_CPL_W-1:0]     portalCpl,
	input  logic [`PORTAL_TASK_W-1:0]    portalTaskId,
	input  logic [`PORTAL_PSO_W-1:0]     portalPso,
	input  portalPkg::cfgRegKind         readSel,
	output logic                         errReport,
	output logic                         portalRst,
	output logic                         portalLock,
	output logic [`PORTAL_STATE_W-1:0]   portalState
);

	import portalPkg::*;

	lockState lockReg;
	logic     errStop;

	// ==============================
	// error handling
	// ==============================
	assign errStop   = mcErrStb && soeFlag;
	assign errReport = mcErrStb && erFlag;

	// run releases the lock even if an error arrives with it
	always_ff @(posedge EXTCLK)
	begin
		if (!RST)
		begin
			lockReg   <= open;
			portalRst <= 1'b0;
		end
		else
		begin
			portalRst <= !errStop;
			if (portalRun)
				lockReg <= open;
			else if (portalDis || errStop)
				lockReg <= locked;
		end
	end

	assign portalLock = (lockReg == locked);

	// ==============================
	// status readback
	// ==============================
	always_comb
	begin
		portalState = '0;
		case (readSel)
			cfgPso:
				portalState[`PORTAL_PSO_W-1:0] = portalPso;
			cfgTask:
			begin
				portalState[`PORTAL_CPL_LSB +: `PORTAL_CPL_W] = portalCpl;
				portalState[`PORTAL_TASK_W-1:0] = portalTaskId;
			end
			default:
				portalState[`PORTAL_CTRL_W-1:0] = ctrlWord;
		endcase
	end

endmodule

// ==== rtl/portalSupervisor.sv ====
`timescale 1ns/1ps
`include "portalCtl_consts.svh"

module portalSupervisor #(
	parameter int tickScale = `PORTAL_TICK_SCALE
) (
	input  logic                             EXTCLK,
	input  logic                             RST,
	input  logic                             cfgStb,
	input  logic                             cfgRst,
	input  logic [`PORTAL_CFG_ADDR_W-1:0]    cfgAddr,
	input  logic [`PORTAL_CFG_DATA_W-1:0]    cfgData,
	input  logic                             portalReady,
	input  logic                             portalActivation,
	input  logic [`PORTAL_CPL_W-1:0]         csrCpl,
	input  logic [`PORTAL_TASK_W-1:0]        csrTaskId,
	input  logic [`PORTAL_PSO_W-1:0]         cpsr,
	input  logic                             portalSmsg,
	input  logic                             mcErrStb,
	input  logic                             portalDis,
	input  logic                             portalRun,
	output logic                             smsgGrant,
	output logic                             errReport,
	output logic                             portalRst,
	output logic                             portalLock,
	output logic [`PORTAL_CPL_W-1:0]         portalCpl,
	output logic [`PORTAL_TASK_W-1:0]        portalTaskId,
	output logic [`PORTAL_PSO_W-1:0]         portalPso,
	output logic [`PORTAL_STATE_W-1:0]       portalState
);

	import portalPkg::*;

	logic                         soeFlag;
	logic                         erFlag;
	logic [`PORTAL_CTRL_W-1:0]    ctrlWord;
	logic [`PORTAL_CNT_W-1:0]     budgetBase;
	logic [`PORTAL_TIMER_W-1:0]   timerBase;
	logic                         rateWrite;
	cfgRegKind                    readSel;

	// configuration side
	portalCfgDecode u_portalCfgDecode (
		.EXTCLK(EXTCLK), .RST(RST), .cfgStb(cfgStb), .cfgAddr(cfgAddr), .cfgData(cfgData),
		.portalReady(portalReady), .portalActivation(portalActivation),
		.csrCpl(csrCpl), .csrTaskId(csrTaskId), .cpsr(cpsr),
		.soeFlag(soeFlag), .erFlag(erFlag), .ctrlWord(ctrlWord),
		.portalCpl(portalCpl), .portalTaskId(portalTaskId), .portalPso(portalPso),
		.budgetBase(budgetBase), .timerBase(timerBase), .rateWrite(rateWrite),
		.readSel(readSel)
	);

	// message rate limit
	msgThrottle #(.tickScale(tickScale)) u_msgThrottle (
		.EXTCLK(EXTCLK), .RST(RST), .cfgRst(cfgRst), .rateWrite(rateWrite),
		.budgetBase(budgetBase), .timerBase(timerBase),
		.portalSmsg(portalSmsg), .smsgGrant(smsgGrant)
	);

	// error, lock and status
	portalGuard u_portalGuard (
		.EXTCLK(EXTCLK), .RST(RST), .mcErrStb(mcErrStb), .portalDis(portalDis),
		.portalRun(portalRun), .soeFlag(soeFlag), .erFlag(erFlag), .ctrlWord(ctrlWord),
		.portalCpl(portalCpl), .portalTaskId(portalTaskId), .portalPso(portalPso),
		.readSel(readSel), .errReport(errReport), .portalRst(portalRst),
		.portalLock(portalLock), .portalState(portalState)
	);

endmodule

// ==== throttle/msgThrottle.sv ====
`timescale 1ns/1ps
`include "portalCtl_consts.svh"

module msgThrottle #(
	parameter int tickScale = `PORTAL_TICK_SCALE
) (
	input  logic                         EXTCLK,
	input  logic                         RST,
	input  logic                         cfgRst,
	input  logic                         rateWrite,
	input  logic [`PORTAL_CNT_W-1:0]     budgetBase,
	input  logic [`PORTAL_TIMER_W-1:0]   timerBase,
	input  logic                         portalSmsg,
	output logic                         smsgGrant
);

	localparam int tickW = (tickScale > 2) ? $clog2(tickScale) : 1;

	logic [tickW-1:0]             tickCnt;
	logic                         tickFlag;
	logic [`PORTAL_CNT_W-1:0]     budgetBaseReg;
	logic [`PORTAL_TIMER_W-1:0]   timerBaseReg;
	logic [`PORTAL_CNT_W-1:0]     budgetCnt;
	logic [`PORTAL_TIMER_W-1:0]   windowTimer;
	logic                         msgEnable;

	// ==============================
	// tick generator
	// ==============================
	// one tick every tickScale cycles, flag is registered
	always_ff @(posedge EXTCLK)
	begin
		if (!RST || tickFlag)
			tickCnt <= '0;
		else
			tickCnt <= tickCnt + 1'b1;
		tickFlag <= RST && (tickCnt == tickW'(tickScale - 2));
	end

	// ==============================
	// budget and window
	// ==============================
	always_ff @(posedge EXTCLK)
	begin
		if (!RST || cfgRst)
		begin
			budgetBaseReg <= '0;
			timerBaseReg  <= '0;
			budgetCnt     <= '0;
			windowTimer   <= '0;
		end
		else
		begin
			if (rateWrite)
			begin
				budgetBaseReg <= budgetBase;
				timerBaseReg  <= timerBase;
			end
			// expired window refills the budget
			if (windowTimer == '0)
			begin
				windowTimer <= timerBaseReg;
				budgetCnt   <= budgetBaseReg;
			end
			else
			begin
				if ((budgetCnt != budgetBaseReg) && tickFlag)
					windowTimer <= windowTimer - 1'b1;
				if ((budgetCnt != '0) && portalSmsg)
					budgetCnt <= budgetCnt - 1'b1;
			end
		end
	end

	// enable lags the counter by a cycle
	always_ff @(posedge EXTCLK)
	begin
		msgEnable <= RST && (budgetCnt != '0);
	end

	assign smsgGrant = portalSmsg && msgEnable && (budgetCnt != '0);

endmodule
